/* src/phys_reg_pkg.sv */
package phys_reg_pkg;

	// Size of the physical register file
	localparam int NUM_PHYS_REG = 64;

	// Bits needed to name one physical register
	localparam int PHYS_BITS = $clog2(NUM_PHYS_REG);

	// Physical register number, used for rename tags and broadcasts
	typedef logic [PHYS_BITS-1:0] phys_tag_t;

	// One row of the map table
	// ready goes high once the value has been broadcast
	typedef struct packed {
		phys_tag_t tag;
		logic      ready;
	} map_row_t;

endpackage

/* src/arch_reg_pkg.sv */
package arch_reg_pkg;

	// Registers visible to the program
	localparam int NUM_ARCH_REG = 32;

	// Architectural register index as it comes from decode
	typedef logic [$clog2(NUM_ARCH_REG)-1:0] arch_reg_t;

	// Occupancy of the single branch checkpoint
	typedef enum logic {
		SLOT_EMPTY = 1'b0,
		SLOT_HELD  = 1'b1
	} slot_state_t;

endpackage

/* src/tag_cam.sv */
`timescale 1ns/1ns

module tag_cam #(
	parameter int SS_SIZE = 2,
	parameter int ENTRIES = 32
) (
	input  logic [SS_SIZE-1:0]                      tags_en,
	input  phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]   tags,
	input  phys_reg_pkg::phys_tag_t [ENTRIES-1:0]   table_in,
	output logic [ENTRIES-1:0][SS_SIZE-1:0]         hits
);

	// Every stored tag is compared against every broadcast lane
	always_comb begin
		for (int e = 0; e < ENTRIES; e++) begin
			for (int w = 0; w < SS_SIZE; w++) begin
				hits[e][w] = tags_en[w] && (tags[w] == table_in[e]); // Idle lanes never hit
			end
		end
	end

endmodule

/* src/map_table.sv */
`timescale 1ns/1ns

module map_table #(
	parameter int SS_SIZE = 2
) (
	input  logic                                                     clock,
	input  logic                                                     reset,
	input  logic                                                     branch_incorrect,
	input  logic [SS_SIZE-1:0]                                       grant,
	input  arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]                    src_a,
	input  arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]                    src_b,
	input  arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]                    dest,
	input  phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]                    alloc_tag,
	input  logic [SS_SIZE-1:0]                                       cdb_en,
	input  phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]                    cdb_tag,
	input  phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0]  saved_map,
	output phys_reg_pkg::map_row_t [SS_SIZE-1:0]                     t1,
	output phys_reg_pkg::map_row_t [SS_SIZE-1:0]                     t2,
	output phys_reg_pkg::map_row_t [SS_SIZE-1:0]                     t_old,
	output phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0]  map_next
);

	phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0]  map_q;    // Committed speculative map
	phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0]  map_work; // Map as this cycle builds it
	phys_reg_pkg::phys_tag_t [arch_reg_pkg::NUM_ARCH_REG-1:0] cam_table;
	logic [arch_reg_pkg::NUM_ARCH_REG-1:0][SS_SIZE-1:0]       cam_hits;

	always_comb begin
		for (int i = 0; i < arch_reg_pkg::NUM_ARCH_REG; i++) begin
			cam_table[i] = map_q[i].tag;
		end
	end

	tag_cam #(
		.SS_SIZE (SS_SIZE),
		.ENTRIES (arch_reg_pkg::NUM_ARCH_REG)
	) u_map_cam (
		.tags_en  (cdb_en),
		.tags     (cdb_tag),
		.table_in (cam_table),
		.hits     (cam_hits)
	);

	// Broadcasts land first so that same-cycle reads already see them ready.
	// Then ways are walked from oldest to youngest, each reading before it writes,
	// which makes an older destination visible to the younger sources
	always_comb begin
		map_work = map_q;
		for (int i = 0; i < arch_reg_pkg::NUM_ARCH_REG; i++) begin
			map_work[i].ready = map_q[i].ready | (|cam_hits[i]);
		end
		for (int w = SS_SIZE - 1; w >= 0; w--) begin
			t1[w]    = map_work[src_a[w]];
			t2[w]    = map_work[src_b[w]];
			t_old[w] = map_work[dest[w]];        // Previous owner goes to the ROB
			if (grant[w]) begin
				map_work[dest[w]].tag   = alloc_tag[w];
				map_work[dest[w]].ready = 1'b0;   // Not produced yet
			end
		end
	end

	// Mispredict drops all of this cycle's work and returns to the snapshot
	assign map_next = branch_incorrect ? saved_map : map_work;

	always_ff @(posedge clock) begin
		if (reset) begin
			// Identity map, everything ready
			for (int i = 0; i < arch_reg_pkg::NUM_ARCH_REG; i++) begin
				map_q[i].tag   <= phys_reg_pkg::phys_tag_t'(i);
				map_q[i].ready <= 1'b1;
			end
		end else begin
			map_q <= map_next;
		end
	end

endmodule

/* src/free_list.sv */
`timescale 1ns/1ns

module free_list #(
	parameter int SS_SIZE = 2
) (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   branch_incorrect,
	input  logic [SS_SIZE-1:0]                     dispatch_en,
	input  logic [SS_SIZE-1:0]                     retire_en,
	input  phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  retire_tag,
	input  logic [phys_reg_pkg::PHYS_BITS:0]       saved_head,
	output logic [SS_SIZE-1:0]                     grant,
	output phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  alloc_tag,
	output logic [phys_reg_pkg::PHYS_BITS:0]       head_next,
	output logic [phys_reg_pkg::PHYS_BITS:0]       free_count
);

	// Pointers carry one extra wrap bit so full and empty differ
	localparam int PTR_BITS   = phys_reg_pkg::PHYS_BITS + 1;
	localparam int RESET_FREE = phys_reg_pkg::NUM_PHYS_REG - arch_reg_pkg::NUM_ARCH_REG;

	phys_reg_pkg::phys_tag_t ring [phys_reg_pkg::NUM_PHYS_REG];

	logic [PTR_BITS-1:0] head;              // Next tag to hand out
	logic [PTR_BITS-1:0] tail;              // Next slot for a retired tag
	logic [PTR_BITS-1:0] tail_next;
	logic [PTR_BITS-1:0] need;              // Tags requested this cycle
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr [SS_SIZE];

	always_comb begin
		need = '0;
		for (int w = 0; w < SS_SIZE; w++) begin
			need = need + PTR_BITS'(dispatch_en[w]);
		end
	end

	assign free_count = tail - head;

	// Whole group or nothing, so the dispatch side never splits a group
	assign grant = (free_count >= need && !branch_incorrect) ? dispatch_en : '0;

	// Oldest granted way takes the head entry, the next one the entry after it
	always_comb begin
		rd_ptr = head;
		for (int w = SS_SIZE - 1; w >= 0; w--) begin
			alloc_tag[w] = ring[rd_ptr[PTR_BITS-2:0]];
			if (grant[w]) begin
				rd_ptr = rd_ptr + 1'b1;
			end
		end
		// Restoring the head gives the squashed tags back in their old order
		head_next = branch_incorrect ? saved_head : rd_ptr;
	end

	// Retire pushes are taken oldest first and apply even on a mispredict
	always_comb begin
		tail_next = tail;
		for (int w = SS_SIZE - 1; w >= 0; w--) begin
			wr_ptr[w] = tail_next;
			if (retire_en[w]) begin
				tail_next = tail_next + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= PTR_BITS'(RESET_FREE);
			// Tags above the identity-mapped range start out free
			for (int i = 0; i < RESET_FREE; i++) begin
				ring[i] <= phys_reg_pkg::phys_tag_t'(i + arch_reg_pkg::NUM_ARCH_REG);
			end
		end else begin
			head <= head_next;
			tail <= tail_next;
			for (int w = 0; w < SS_SIZE; w++) begin
				if (retire_en[w]) begin
					ring[wr_ptr[w][PTR_BITS-2:0]] <= retire_tag[w];
				end
			end
		end
	end

endmodule

/* src/branch_checkpoint.sv */
`timescale 1ns/1ns

module branch_checkpoint #(
	parameter int SS_SIZE = 2
) (
	input  logic                                                     clock,
	input  logic                                                     reset,
	input  logic                                                     branch_incorrect,
	input  logic                                                     take,
	input  phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0]  map_next,
	input  logic [phys_reg_pkg::PHYS_BITS:0]                         head_next,
	input  logic [SS_SIZE-1:0]                                       cdb_en,
	input  phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]                    cdb_tag,
	output phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0]  saved_map,
	output logic [phys_reg_pkg::PHYS_BITS:0]                         saved_head
);

	arch_reg_pkg::slot_state_t                                state;
	phys_reg_pkg::phys_tag_t [arch_reg_pkg::NUM_ARCH_REG-1:0] cam_table;
	logic [arch_reg_pkg::NUM_ARCH_REG-1:0][SS_SIZE-1:0]       cam_hits;

	always_comb begin
		for (int i = 0; i < arch_reg_pkg::NUM_ARCH_REG; i++) begin
			cam_table[i] = saved_map[i].tag;
		end
	end

	// Separate CAM so the snapshot keeps tracking results while the branch is pending
	tag_cam #(
		.SS_SIZE (SS_SIZE),
		.ENTRIES (arch_reg_pkg::NUM_ARCH_REG)
	) u_ckpt_cam (
		.tags_en  (cdb_en),
		.tags     (cdb_tag),
		.table_in (cam_table),
		.hits     (cam_hits)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= arch_reg_pkg::SLOT_EMPTY;
		end else if (branch_incorrect) begin
			state <= arch_reg_pkg::SLOT_EMPTY; // Snapshot consumed by the restore
		end else if (take) begin
			state <= arch_reg_pkg::SLOT_HELD;
		end
	end

	// The snapshot is the map after the whole dispatch group holding the branch.
	// map_next already carries this cycle's broadcasts, so none are lost on capture
	always_ff @(posedge clock) begin
		if (take) begin
			saved_map  <= map_next;  // A newer branch simply replaces the old one
			saved_head <= head_next;
		end else if (state == arch_reg_pkg::SLOT_HELD) begin
			for (int i = 0; i < arch_reg_pkg::NUM_ARCH_REG; i++) begin
				saved_map[i].ready <= saved_map[i].ready | (|cam_hits[i]);
			end
		end
	end

endmodule

/* src/rename_stage.sv */
`timescale 1ns/1ns

module rename_stage #(
	parameter int SS_SIZE = 2,
	localparam int WAY_BITS = (SS_SIZE > 1) ? $clog2(SS_SIZE) : 1
) (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic [SS_SIZE-1:0]                     dispatch_en,
	input  arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]  src_a,
	input  arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]  src_b,
	input  arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]  dest,
	input  logic [SS_SIZE-1:0]                     cdb_en,
	input  phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  cdb_tag,
	input  logic [SS_SIZE-1:0]                     retire_en,
	input  phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  retire_tag,
	input  logic                                   branch_en,
	input  logic [WAY_BITS-1:0]                    branch_way,
	input  logic                                   branch_incorrect,
	output logic [SS_SIZE-1:0]                     grant,
	output phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  new_tag,
	output phys_reg_pkg::map_row_t [SS_SIZE-1:0]   t1,
	output phys_reg_pkg::map_row_t [SS_SIZE-1:0]   t2,
	output phys_reg_pkg::map_row_t [SS_SIZE-1:0]   t_old,
	output logic [phys_reg_pkg::PHYS_BITS:0]       free_count
);

	phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0] map_next;
	phys_reg_pkg::map_row_t [arch_reg_pkg::NUM_ARCH_REG-1:0] saved_map;
	logic [phys_reg_pkg::PHYS_BITS:0]                        head_next;
	logic [phys_reg_pkg::PHYS_BITS:0]                        saved_head;
	logic                                                    take;

	// Only a branch that actually got renamed may take the checkpoint
	assign take = branch_en & grant[branch_way];

	free_list #(
		.SS_SIZE (SS_SIZE)
	) u_free_list (
		.clock            (clock),
		.reset            (reset),
		.branch_incorrect (branch_incorrect),
		.dispatch_en      (dispatch_en),
		.retire_en        (retire_en),
		.retire_tag       (retire_tag),
		.saved_head       (saved_head),
		.grant            (grant),
		.alloc_tag        (new_tag),   // New tags feed the map and leave as results
		.head_next        (head_next),
		.free_count       (free_count)
	);

	map_table #(
		.SS_SIZE (SS_SIZE)
	) u_map_table (
		.clock            (clock),
		.reset            (reset),
		.branch_incorrect (branch_incorrect),
		.grant            (grant),
		.src_a            (src_a),
		.src_b            (src_b),
		.dest             (dest),
		.alloc_tag        (new_tag),
		.cdb_en           (cdb_en),
		.cdb_tag          (cdb_tag),
		.saved_map        (saved_map),
		.t1               (t1),
		.t2               (t2),
		.t_old            (t_old),
		.map_next         (map_next)
	);

	branch_checkpoint #(
		.SS_SIZE (SS_SIZE)
	) u_checkpoint (
		.clock            (clock),
		.reset            (reset),
		.branch_incorrect (branch_incorrect),
		.take             (take),
		.map_next         (map_next),
		.head_next        (head_next),
		.cdb_en           (cdb_en),
		.cdb_tag          (cdb_tag),
		.saved_map        (saved_map),
		.saved_head       (saved_head)
	);

endmodule

/* testbench/rename_checker.sv */
`timescale 1ns/1ns

module rename_checker #(
	parameter int SS_SIZE  = 2,
	parameter int WAY_BITS = 1
) (
	input logic                                   clock,
	input logic                                   reset,
	input logic [SS_SIZE-1:0]                     dispatch_en,
	input arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]  src_a,
	input arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]  src_b,
	input arch_reg_pkg::arch_reg_t [SS_SIZE-1:0]  dest,
	input logic [SS_SIZE-1:0]                     cdb_en,
	input phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  cdb_tag,
	input logic [SS_SIZE-1:0]                     retire_en,
	input phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  retire_tag,
	input logic                                   branch_en,
	input logic [WAY_BITS-1:0]                    branch_way,
	input logic                                   branch_incorrect,
	input logic [SS_SIZE-1:0]                     grant,
	input phys_reg_pkg::phys_tag_t [SS_SIZE-1:0]  new_tag,
	input phys_reg_pkg::map_row_t [SS_SIZE-1:0]   t1,
	input phys_reg_pkg::map_row_t [SS_SIZE-1:0]   t2,
	input phys_reg_pkg::map_row_t [SS_SIZE-1:0]   t_old,
	input logic [phys_reg_pkg::PHYS_BITS:0]       free_count
);

	localparam int NA = arch_reg_pkg::NUM_ARCH_REG;

	phys_reg_pkg::map_row_t  map_m [NA];   // Reference speculative map
	phys_reg_pkg::map_row_t  saved_m [NA]; // Reference snapshot
	phys_reg_pkg::map_row_t  work [NA];
	phys_reg_pkg::phys_tag_t free_q[$];    // Free tags in allocation order
	phys_reg_pkg::phys_tag_t saved_q[$];   // Free list as it would look after a restore
	logic [SS_SIZE-1:0]      exp_grant;
	int                      error_count = 0;
	int                      check_count = 0;

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic cdb_hit(input phys_reg_pkg::phys_tag_t tag);
		logic hit;
		hit = 1'b0;
		for (int w = 0; w < SS_SIZE; w++) begin
			if (cdb_en[w] && cdb_tag[w] == tag) hit = 1'b1;
		end
		return hit;
	endfunction

	task automatic reset_model();
		free_q.delete();
		saved_q.delete();
		for (int i = 0; i < NA; i++) begin
			map_m[i].tag   = phys_reg_pkg::phys_tag_t'(i);
			map_m[i].ready = 1'b1;
			saved_m[i]     = map_m[i];
		end
		for (int t = NA; t < phys_reg_pkg::NUM_PHYS_REG; t++) begin
			free_q.push_back(phys_reg_pkg::phys_tag_t'(t));
		end
	endtask

	task automatic step_model();
		int need;
		int k;
		need = 0;
		for (int w = 0; w < SS_SIZE; w++) need += dispatch_en[w];
		// All or nothing, and nothing at all during a mispredict
		exp_grant = (free_q.size() >= need && !branch_incorrect) ? dispatch_en : '0;
		check_value("grant", 8'(grant), 8'(exp_grant));
		check_value("free_count", 8'(free_count), 8'(free_q.size()));
		for (int i = 0; i < NA; i++) begin
			work[i] = map_m[i];
			if (cdb_hit(map_m[i].tag)) work[i].ready = 1'b1;  // Broadcasts before reads
		end
		k = 0;
		for (int w = SS_SIZE - 1; w >= 0; w--) begin
			check_value($sformatf("t1[%0d]", w), 8'(t1[w]), 8'(work[src_a[w]]));
			check_value($sformatf("t2[%0d]", w), 8'(t2[w]), 8'(work[src_b[w]]));
			check_value($sformatf("t_old[%0d]", w), 8'(t_old[w]), 8'(work[dest[w]]));
			if (exp_grant[w]) begin
				check_value($sformatf("new_tag[%0d]", w), 8'(new_tag[w]), 8'(free_q[k]));
				work[dest[w]].tag   = free_q[k];
				work[dest[w]].ready = 1'b0;
				k++;
			end
		end
		if (branch_incorrect) begin
			map_m  = saved_m;
			free_q = saved_q;  // Squashed tags come back first, in their old order
		end else begin
			for (int j = 0; j < k; j++) free_q.delete(0);
			map_m = work;
			if (branch_en && exp_grant[branch_way]) begin
				saved_m = work;
				saved_q = free_q;
			end else begin
				for (int i = 0; i < NA; i++) begin
					if (cdb_hit(saved_m[i].tag)) saved_m[i].ready = 1'b1;
				end
			end
		end
		// Retired tags go in behind the free ones, oldest way first
		for (int w = SS_SIZE - 1; w >= 0; w--) begin
			if (retire_en[w]) begin
				free_q.push_back(retire_tag[w]);
				saved_q.push_back(retire_tag[w]);
			end
		end
	endtask

	always @(posedge clock) begin
		if (reset) reset_model();
		else step_model();
	end

endmodule

/* testbench/tb_rename.sv */
`timescale 1ns/1ns

module tb_rename;

	localparam int SS_SIZE        = 2;
	localparam int WAY_BITS       = (SS_SIZE > 1) ? $clog2(SS_SIZE) : 1;
	localparam int RESET_CYCLES   = 3;
	localparam int NUM_CYCLES     = 2000;
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

	logic                                  clock;
	logic                                  reset;
	logic [SS_SIZE-1:0]                    dispatch_en;
	arch_reg_pkg::arch_reg_t [SS_SIZE-1:0] src_a;
	arch_reg_pkg::arch_reg_t [SS_SIZE-1:0] src_b;
	arch_reg_pkg::arch_reg_t [SS_SIZE-1:0] dest;
	logic [SS_SIZE-1:0]                    cdb_en;
	phys_reg_pkg::phys_tag_t [SS_SIZE-1:0] cdb_tag;
	logic [SS_SIZE-1:0]                    retire_en;
	phys_reg_pkg::phys_tag_t [SS_SIZE-1:0] retire_tag;
	logic                                  branch_en;
	logic [WAY_BITS-1:0]                   branch_way;
	logic                                  branch_incorrect;
	logic [SS_SIZE-1:0]                    grant;
	phys_reg_pkg::phys_tag_t [SS_SIZE-1:0] new_tag;
	phys_reg_pkg::map_row_t [SS_SIZE-1:0]  t1;
	phys_reg_pkg::map_row_t [SS_SIZE-1:0]  t2;
	phys_reg_pkg::map_row_t [SS_SIZE-1:0]  t_old;
	logic [phys_reg_pkg::PHYS_BITS:0]      free_count;

	logic [31:0]             rng_state;
	phys_reg_pkg::phys_tag_t rob_new[$];  // In-flight destinations
	phys_reg_pkg::phys_tag_t rob_old[$];  // Tags freed when each entry retires
	bit                      rob_done[$]; // Result already broadcast
	bit                      held;
	int                      keep;        // ROB entries up to and including the branch group
	int                      cycle_count = 0;

	always #20 clock = ~clock;

	rename_stage #(.SS_SIZE(SS_SIZE)) uut (.*);

	rename_checker #(.SS_SIZE(SS_SIZE), .WAY_BITS(WAY_BITS)) u_checker (.*);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic clear_inputs();
		dispatch_en      = '0;
		src_a            = '0;
		src_b            = '0;
		dest             = '0;
		cdb_en           = '0;
		cdb_tag          = '0;
		retire_en        = '0;
		retire_tag       = '0;
		branch_en        = 1'b0;
		branch_way       = '0;
		branch_incorrect = 1'b0;
	endtask

	task automatic drive_cycle();
		logic [31:0] r;
		int          start;
		int          idx;
		bit          found;
		clear_inputs();
		r = next_random();
		if (held && r[2:0] == 3'd0) branch_incorrect = 1'b1;
		else if (held && r[2:0] == 3'd1) held = 1'b0;  // Branch resolved as predicted
		// A mispredict cycle still carries a group, a branch and broadcasts for the DUT to drop
		for (int w = 0; w < SS_SIZE; w++) begin
			r              = next_random();
			dispatch_en[w] = (r[1:0] != 2'd0);
			src_a[w]       = r[8:4];
			src_b[w]       = r[13:9];
			dest[w]        = r[18:14];
		end
		r          = next_random();
		branch_way = WAY_BITS'(r % SS_SIZE);
		branch_en  = (r[9:8] == 2'd0) && dispatch_en[branch_way];
		// Broadcast only results that are in flight and not yet sent
		for (int w = 0; w < SS_SIZE; w++) begin
			r     = next_random();
			found = 1'b0;
			if (r[0] && rob_new.size() > 0) begin
				start = (r >> 4) % rob_new.size();
				for (int j = 0; j < rob_new.size(); j++) begin
					idx = (start + j) % rob_new.size();
					if (!found && !rob_done[idx]) begin
						found         = 1'b1;
						cdb_en[w]     = 1'b1;
						cdb_tag[w]    = rob_new[idx];
						rob_done[idx] = !branch_incorrect; // A dropped result is sent again later
					end
				end
			end
		end
		// In-order retire, never past a pending branch
		for (int w = SS_SIZE - 1; w >= 0; w--) begin
			r = next_random();
			if (rob_new.size() > 0 && rob_done[0] && (!held || keep > 0) && r[1:0] != 2'd0) begin
				retire_en[w]  = 1'b1;
				retire_tag[w] = rob_old.pop_front();
				void'(rob_new.pop_front());
				void'(rob_done.pop_front());
				if (held) keep--;
			end
		end
	endtask

	task automatic record_cycle();
		for (int w = SS_SIZE - 1; w >= 0; w--) begin
			if (grant[w]) begin
				rob_new.push_back(new_tag[w]);
				rob_old.push_back(t_old[w].tag);
				rob_done.push_back(1'b0);
			end
		end
		if (branch_incorrect) begin
			while (rob_new.size() > keep) begin  // Squash everything younger than the branch
				void'(rob_new.pop_back());
				void'(rob_old.pop_back());
				void'(rob_done.pop_back());
			end
			held = 1'b0;
		end else if (branch_en && grant[branch_way]) begin
			held = 1'b1;
			keep = rob_new.size();
		end
	endtask

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		rng_state = 32'h2b65;
		clock     = 1'b0;
		reset     = 1'b1;
		held      = 1'b0;
		keep      = 0;
		clear_inputs();
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int c = 0; c < NUM_CYCLES; c++) begin
			@(negedge clock);
			drive_cycle();
			@(posedge clock);
			record_cycle();
		end
		@(negedge clock);
		$display("Checks: %0d  errors: %0d", u_checker.check_count, u_checker.error_count);
		if (u_checker.error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
src/phys_reg_pkg.sv
src/arch_reg_pkg.sv
src/tag_cam.sv
src/map_table.sv
src/free_list.sv
src/branch_checkpoint.sv
src/rename_stage.sv
testbench/rename_checker.sv
testbench/tb_rename.sv
